/* common/ipic_pkg.sv */
// Shared sizes, register map, ICSR bit layout and types; imported by every IPIC module
`default_nettype none

package ipic_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int IRQ_VECT_NUM   = 16;     // Number of interrupt lines
    localparam int IRQ_IDX_WIDTH  = 4;      // Line index width
    localparam int IRQ_VECT_WIDTH = 5;      // Vector number incl. void bit
    localparam int XLEN           = 32;     // CSR data width

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [IRQ_VECT_NUM-1:0]   irq_vec_t;   // One bit per line
    typedef logic [IRQ_IDX_WIDTH-1:0]  irq_idx_t;   // Line index
    typedef logic [IRQ_VECT_WIDTH-1:0] irq_vect_t;  // Vector number, MSB marks void
    typedef logic [2:0]                csr_addr_t;  // Register address
    typedef logic [XLEN-1:0]           csr_data_t;  // CSR word

    // Nothing in service
    localparam irq_vect_t IRQ_VOID_VECT = irq_vect_t'(IRQ_VECT_NUM);

    // ----------------------------------------
    // Register addresses
    // ----------------------------------------
    localparam csr_addr_t ADDR_CISV  = 3'd0;    // Current vector in service
    localparam csr_addr_t ADDR_CICSR = 3'd1;    // Current line control/status
    localparam csr_addr_t ADDR_IPR   = 3'd2;    // Pending vector
    localparam csr_addr_t ADDR_ISVR  = 3'd3;    // In-service vector
    localparam csr_addr_t ADDR_EOI   = 3'd4;    // End of interrupt
    localparam csr_addr_t ADDR_SOI   = 3'd5;    // Start of interrupt
    localparam csr_addr_t ADDR_IDX   = 3'd6;    // Index for ICSR window
    localparam csr_addr_t ADDR_ICSR  = 3'd7;    // Indexed control/status

    // ICSR bit positions, CICSR shares IP and IE
    localparam int ICSR_IP      = 0;    // Pending
    localparam int ICSR_IE      = 1;    // Enable
    localparam int ICSR_IM      = 2;    // Mode, 1 = edge
    localparam int ICSR_INV     = 3;    // Line inversion
    localparam int ICSR_IS      = 4;    // In service
    localparam int ICSR_PRV_LSB = 8;
    localparam int ICSR_PRV_MSB = 9;
    localparam int ICSR_LN_LSB  = 12;   // 4-bit line number starts here

    // Privilege code reported in ICSR
    localparam logic [1:0] PRV_M = 2'd3;

endpackage : ipic_pkg

`default_nettype wire

/* common/ipic_reg_if.sv */
// Decoded register strobes and write fields, from the CSR decoder to the IPIC datapath
`timescale 1ns/1ps
`default_nettype none

interface ipic_reg_if;
    import ipic_pkg::*;

    // One-cycle write strobes
    logic     wr_cicsr;
    logic     wr_ipr;
    logic     wr_eoi;
    logic     wr_soi;
    logic     wr_icsr;

    // Write data fields
    logic     wd_ip;
    logic     wd_ie;
    logic     wd_im;
    logic     wd_inv;
    irq_vec_t wd_vec;   // Low bits of write data, IPR clear mask

    irq_idx_t idx;      // Current index register

    modport ctrl (output wr_cicsr, wr_ipr, wr_eoi, wr_soi, wr_icsr,
                  output wd_ip, wd_ie, wd_im, wd_inv, wd_vec, idx);

    modport dp   (input wr_cicsr, wr_ipr, wr_eoi, wr_soi, wr_icsr,
                  input wd_ip, wd_ie, wd_im, wd_inv, wd_vec, idx);

endinterface : ipic_reg_if

`default_nettype wire

/* source/ipic_line_frontend.sv */
// IRQ line front end: two-flop sync, inversion, level and edge detection for the pending logic
`timescale 1ns/1ps
`default_nettype none

module ipic_line_frontend (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire ipic_pkg::irq_vec_t irq_lines_i,    // Raw asynchronous lines
    input  wire ipic_pkg::irq_vec_t iinv_next_i,    // Inversion incl. write this cycle
    output      ipic_pkg::irq_vec_t irq_lvl_o,      // Active level per line
    output      ipic_pkg::irq_vec_t irq_edge_o      // Active edge seen this cycle
);
    import ipic_pkg::*;

    irq_vec_t lines_meta;   // First sync stage
    irq_vec_t lines_sync;   // Safe to use
    irq_vec_t lines_dly;    // Previous synced value

    // Sync chain plus delay for edge compare
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lines_meta <= '0;
            lines_sync <= '0;
            lines_dly  <= '0;
        end else begin
            lines_meta <= irq_lines_i;
            lines_sync <= lines_meta;
            lines_dly  <= lines_sync;
        end
    end

    assign irq_lvl_o  = lines_sync ^ iinv_next_i;               // Polarity corrected
    assign irq_edge_o = (lines_dly ^ lines_sync) & irq_lvl_o;   // Change into active level

endmodule : ipic_line_frontend

`default_nettype wire

/* source/ipic_priority_search.sv */
// Fixed-priority search: lowest set bit of a 16-bit line vector, used for request and EOI lookups
`timescale 1ns/1ps
`default_nettype none

module ipic_priority_search (
    input  wire ipic_pkg::irq_vec_t vec_i,
    output logic                    vd_o,   // Any bit set
    output      ipic_pkg::irq_idx_t idx_o   // Lowest set index
);

    logic [7:0] l1_vd;          // Pairs of bits
    logic [7:0] l1_idx;
    logic [3:0] l2_vd;          // Groups of four
    logic [1:0] l2_idx [4];
    logic [1:0] l3_vd;          // Groups of eight
    logic [2:0] l3_idx [2];

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            l1_vd[i]  = vec_i[2*i] | vec_i[2*i+1];
            l1_idx[i] = ~vec_i[2*i];                // Upper bit only if lower clear
        end
        for (int i = 0; i < 4; i++) begin
            l2_vd[i]  = l1_vd[2*i] | l1_vd[2*i+1];
            l2_idx[i] = l1_vd[2*i] ? {1'b0, l1_idx[2*i]} : {1'b1, l1_idx[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            l3_vd[i]  = l2_vd[2*i] | l2_vd[2*i+1];
            l3_idx[i] = l2_vd[2*i] ? {1'b0, l2_idx[2*i]} : {1'b1, l2_idx[2*i+1]};
        end
    end

    // Last level, lower half wins
    assign vd_o  = |l3_vd;
    assign idx_o = l3_vd[0] ? {1'b0, l3_idx[0]} : {1'b1, l3_idx[1]};

endmodule : ipic_priority_search

`default_nettype wire

/* ipic_core/ipic_csr_ctrl.sv */
// CSR access decoder: write strobes, index register and read data mux for the IPIC registers
`timescale 1ns/1ps
`default_nettype none

module ipic_csr_ctrl (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                csr_r_req_i,
    input  wire logic                csr_w_req_i,
    input  wire ipic_pkg::csr_addr_t csr_addr_i,
    input  wire ipic_pkg::csr_data_t csr_wdata_i,
    output      ipic_pkg::csr_data_t csr_rdata_o,
    input  wire ipic_pkg::irq_vec_t  ipr_i,
    input  wire ipic_pkg::irq_vec_t  ier_i,
    input  wire ipic_pkg::irq_vec_t  imr_i,
    input  wire ipic_pkg::irq_vec_t  iinv_i,
    input  wire ipic_pkg::irq_vec_t  isvr_i,
    input  wire ipic_pkg::irq_vect_t cisv_i,
    ipic_reg_if.ctrl                 reg_o
);
    import ipic_pkg::*;

    irq_idx_t idx_ff;       // Index register
    logic     serv_vd;      // Something in service
    irq_idx_t serv_idx;

    // ----------------------------------------
    // Write decode
    // ----------------------------------------
    assign reg_o.wr_cicsr = csr_w_req_i & (csr_addr_i == ADDR_CICSR);
    assign reg_o.wr_ipr   = csr_w_req_i & (csr_addr_i == ADDR_IPR);
    assign reg_o.wr_eoi   = csr_w_req_i & (csr_addr_i == ADDR_EOI);
    assign reg_o.wr_soi   = csr_w_req_i & (csr_addr_i == ADDR_SOI);
    assign reg_o.wr_icsr  = csr_w_req_i & (csr_addr_i == ADDR_ICSR);

    // Field extraction, same bits for ICSR and CICSR
    assign reg_o.wd_ip  = csr_wdata_i[ICSR_IP];
    assign reg_o.wd_ie  = csr_wdata_i[ICSR_IE];
    assign reg_o.wd_im  = csr_wdata_i[ICSR_IM];
    assign reg_o.wd_inv = csr_wdata_i[ICSR_INV];
    assign reg_o.wd_vec = csr_wdata_i[IRQ_VECT_NUM-1:0];
    assign reg_o.idx    = idx_ff;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_ff <= '0;
        end else if (csr_w_req_i && (csr_addr_i == ADDR_IDX)) begin
            idx_ff <= csr_wdata_i[IRQ_IDX_WIDTH-1:0];
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    assign serv_vd  = ~cisv_i[IRQ_VECT_WIDTH-1];    // MSB set means void
    assign serv_idx = cisv_i[IRQ_IDX_WIDTH-1:0];

    always_comb begin
        csr_rdata_o = '0;
        if (csr_r_req_i) begin
            case (csr_addr_i)
                ADDR_CISV: begin
                    csr_rdata_o = csr_data_t'(cisv_i);
                end
                ADDR_CICSR: begin
                    csr_rdata_o[ICSR_IP] = ipr_i[serv_idx] & serv_vd;
                    csr_rdata_o[ICSR_IE] = ier_i[serv_idx] & serv_vd;
                end
                ADDR_IPR:  csr_rdata_o = csr_data_t'(ipr_i);
                ADDR_ISVR: csr_rdata_o = csr_data_t'(isvr_i);
                ADDR_EOI,
                ADDR_SOI:  csr_rdata_o = '0;            // Write-only
                ADDR_IDX:  csr_rdata_o = csr_data_t'(idx_ff);
                ADDR_ICSR: begin
                    csr_rdata_o[ICSR_IP]  = ipr_i[idx_ff];
                    csr_rdata_o[ICSR_IE]  = ier_i[idx_ff];
                    csr_rdata_o[ICSR_IM]  = imr_i[idx_ff];
                    csr_rdata_o[ICSR_INV] = iinv_i[idx_ff];
                    csr_rdata_o[ICSR_IS]  = isvr_i[idx_ff];
                    csr_rdata_o[ICSR_PRV_MSB:ICSR_PRV_LSB] = PRV_M;
                    csr_rdata_o[ICSR_LN_LSB +: IRQ_IDX_WIDTH] = idx_ff;  // Line number
                end
            endcase
        end
    end

endmodule : ipic_csr_ctrl

`default_nettype wire

/* ipic_core/ipic_line_regs.sv */
// Per-line register bank: pending, enable, mode and inversion, with the pending clear rules
`timescale 1ns/1ps
`default_nettype none

module ipic_line_regs (
    input  wire logic               clk,
    input  wire logic               rst_n,
    ipic_reg_if.dp                  reg_i,
    input  wire ipic_pkg::irq_vec_t irq_lvl_i,
    input  wire ipic_pkg::irq_vec_t irq_edge_i,
    input  wire logic               serv_vd_i,      // Line in service valid
    input  wire ipic_pkg::irq_idx_t serv_idx_i,
    input  wire logic               req_vd_i,       // Pending and enabled line exists
    input  wire ipic_pkg::irq_idx_t req_idx_i,
    output      ipic_pkg::irq_vec_t ipr_o,
    output      ipic_pkg::irq_vec_t ier_o,
    output      ipic_pkg::irq_vec_t imr_o,
    output      ipic_pkg::irq_vec_t iinv_o,
    output      ipic_pkg::irq_vec_t iinv_next_o
);
    import ipic_pkg::*;

    irq_vec_t ipr_ff, ipr_next;
    irq_vec_t ier_ff, ier_next;
    irq_vec_t imr_ff, imr_next;
    irq_vec_t iinv_ff, iinv_next;
    irq_vec_t clr_req;              // Requested pending clears
    irq_vec_t clr;                  // Clears that are allowed

    // ----------------------------------------
    // Config registers, IER IMR IINVR
    // ----------------------------------------
    always_comb begin
        ier_next  = ier_ff;
        imr_next  = imr_ff;
        iinv_next = iinv_ff;
        if (reg_i.wr_cicsr && serv_vd_i) begin
            ier_next[serv_idx_i] = reg_i.wd_ie;     // Enable of line in service
        end
        if (reg_i.wr_icsr) begin
            ier_next[reg_i.idx]  = reg_i.wd_ie;
            imr_next[reg_i.idx]  = reg_i.wd_im;
            iinv_next[reg_i.idx] = reg_i.wd_inv;
        end
    end

    // Pending clear sources
    always_comb begin
        clr_req = '0;
        if (reg_i.wr_cicsr) clr_req[serv_idx_i] = reg_i.wd_ip & serv_vd_i;
        if (reg_i.wr_ipr)   clr_req = reg_i.wd_vec;
        if (reg_i.wr_soi)   clr_req[req_idx_i] = req_vd_i;  // Line being started
        if (reg_i.wr_icsr)  clr_req[reg_i.idx] = reg_i.wd_ip;
    end

    // Active level lines stay pending unless in edge mode
    assign clr = clr_req & (~irq_lvl_i | imr_next);

    always_comb begin
        for (int i = 0; i < IRQ_VECT_NUM; i++) begin
            if (clr[i])           ipr_next[i] = 1'b0;
            else if (!imr_ff[i])  ipr_next[i] = irq_lvl_i[i];              // Level follows
            else                  ipr_next[i] = ipr_ff[i] | irq_edge_i[i]; // Edge sticks
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ipr_ff  <= '0;
            ier_ff  <= '0;
            imr_ff  <= '0;
            iinv_ff <= '0;
        end else begin
            ipr_ff  <= ipr_next;
            ier_ff  <= ier_next;
            imr_ff  <= imr_next;
            iinv_ff <= iinv_next;
        end
    end

    assign ipr_o       = ipr_ff;
    assign ier_o       = ier_ff;
    assign imr_o       = imr_ff;
    assign iinv_o      = iinv_ff;
    assign iinv_next_o = iinv_next;     // Same-cycle inversion for the front end

endmodule : ipic_line_regs

`default_nettype wire

/* ipic_core/ipic_service.sv */
// Service tracker: CISV and ISVR, SOI/EOI handling, preemption compare and the M-level request
`timescale 1ns/1ps
`default_nettype none

module ipic_service (
    input  wire logic                clk,
    input  wire logic                rst_n,
    ipic_reg_if.dp                   reg_i,
    input  wire ipic_pkg::irq_vec_t  ipr_i,
    input  wire ipic_pkg::irq_vec_t  ier_i,
    output      ipic_pkg::irq_vect_t cisv_o,
    output      ipic_pkg::irq_vec_t  isvr_o,
    output logic                     serv_vd_o,
    output      ipic_pkg::irq_idx_t  serv_idx_o,
    output logic                     req_vd_o,
    output      ipic_pkg::irq_idx_t  req_idx_o,
    output logic                     irq_m_req_o
);
    import ipic_pkg::*;

    irq_vect_t cisv_ff;
    irq_vec_t  isvr_ff;
    irq_vec_t  isvr_eoi;        // In-service set minus current line
    logic      serv_vd;
    irq_idx_t  serv_idx;
    logic      req_vd, eoi_vd;
    irq_idx_t  req_idx, eoi_idx;
    logic      start_vd;        // SOI accepted
    logic      eoi_req;         // EOI accepted

    assign serv_vd  = ~cisv_ff[IRQ_VECT_WIDTH-1];
    assign serv_idx = cisv_ff[IRQ_IDX_WIDTH-1:0];

    ipic_priority_search u_req_search (
        .vec_i (ipr_i & ier_i),
        .vd_o  (req_vd),
        .idx_o (req_idx)
    );

    always_comb begin
        isvr_eoi = isvr_ff;
        if (serv_vd) isvr_eoi[serv_idx] = 1'b0;
    end

    // Next line to return to after EOI
    ipic_priority_search u_eoi_search (
        .vec_i (isvr_eoi),
        .vd_o  (eoi_vd),
        .idx_o (eoi_idx)
    );

    // Request only if idle or strictly higher priority than current
    assign irq_m_req_o = req_vd & (~serv_vd | (req_idx < serv_idx));
    assign start_vd    = reg_i.wr_soi & irq_m_req_o;
    assign eoi_req     = reg_i.wr_eoi & serv_vd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cisv_ff <= IRQ_VOID_VECT;
            isvr_ff <= '0;
        end else if (start_vd) begin
            cisv_ff          <= {1'b0, req_idx};
            isvr_ff[req_idx] <= 1'b1;
        end else if (eoi_req) begin
            cisv_ff <= eoi_vd ? {1'b0, eoi_idx} : IRQ_VOID_VECT;
            isvr_ff <= isvr_eoi;
        end
    end

    assign cisv_o     = cisv_ff;
    assign isvr_o     = isvr_ff;
    assign serv_vd_o  = serv_vd;
    assign serv_idx_o = serv_idx;
    assign req_vd_o   = req_vd;
    assign req_idx_o  = req_idx;

endmodule : ipic_service

`default_nettype wire

/* source/ipic_top.sv */
// IPIC top level: connects the CSR decoder and datapath blocks to the core's CSR port and IRQ pins
`timescale 1ns/1ps
`default_nettype none

module ipic_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire ipic_pkg::irq_vec_t  irq_lines_i,
    input  wire logic                csr_r_req_i,
    input  wire logic                csr_w_req_i,
    input  wire ipic_pkg::csr_addr_t csr_addr_i,
    input  wire ipic_pkg::csr_data_t csr_wdata_i,
    output      ipic_pkg::csr_data_t csr_rdata_o,
    output logic                     irq_m_req_o
);
    import ipic_pkg::*;

    ipic_reg_if reg_bus ();     // Decoder to datapath

    irq_vec_t  irq_lvl, irq_edge;
    irq_vec_t  ipr, ier, imr, iinvr, iinv_next, isvr;
    irq_vect_t cisv;
    logic      serv_vd, req_vd;
    irq_idx_t  serv_idx, req_idx;

    ipic_csr_ctrl u_csr_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_r_req_i (csr_r_req_i),
        .csr_w_req_i (csr_w_req_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .ipr_i       (ipr),
        .ier_i       (ier),
        .imr_i       (imr),
        .iinv_i      (iinvr),
        .isvr_i      (isvr),
        .cisv_i      (cisv),
        .reg_o       (reg_bus.ctrl)
    );

    ipic_line_frontend u_frontend (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines_i),
        .iinv_next_i (iinv_next),
        .irq_lvl_o   (irq_lvl),
        .irq_edge_o  (irq_edge)
    );

    ipic_line_regs u_line_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_i       (reg_bus.dp),
        .irq_lvl_i   (irq_lvl),
        .irq_edge_i  (irq_edge),
        .serv_vd_i   (serv_vd),
        .serv_idx_i  (serv_idx),
        .req_vd_i    (req_vd),
        .req_idx_i   (req_idx),
        .ipr_o       (ipr),
        .ier_o       (ier),
        .imr_o       (imr),
        .iinv_o      (iinvr),
        .iinv_next_o (iinv_next)
    );

    ipic_service u_service (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_i       (reg_bus.dp),
        .ipr_i       (ipr),
        .ier_i       (ier),
        .cisv_o      (cisv),
        .isvr_o      (isvr),
        .serv_vd_o   (serv_vd),
        .serv_idx_o  (serv_idx),
        .req_vd_o    (req_vd),
        .req_idx_o   (req_idx),
        .irq_m_req_o (irq_m_req_o)
    );

endmodule : ipic_top

`default_nettype wire

/* bench/ipic_clkgen.sv */
// Testbench clock and reset source for the IPIC testbench, 20 ns clock with reset held 5 cycles
`timescale 1ns/1ps
`default_nettype none

module ipic_clkgen (
    output logic clk_o,
    output logic rst_n_o
);
    localparam int CLK_PERIOD = 20;     // ns
    localparam int RST_CYCLES = 5;
    localparam int DRV_DLY    = 2;      // Release just after the edge

    initial begin
        clk_o = 1'b0;
        forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #DRV_DLY rst_n_o = 1'b1;
    end

endmodule : ipic_clkgen

`default_nettype wire

/* bench/ipic_checker.sv */
// Testbench checker: compares read data and the request output with expected values, per test
`timescale 1ns/1ps
`default_nettype none

module ipic_checker (
    input  wire logic                clk,
    input  wire ipic_pkg::csr_data_t rdata_i,       // DUT read data
    input  wire logic                irq_req_i,     // DUT request output
    input  wire logic                check_i,       // Compare in this cycle
    input  wire logic                check_req_i,   // 1 = request, 0 = read data
    input  wire ipic_pkg::csr_data_t exp_i,
    input  wire logic [127:0]        name_i,        // Test name, ASCII
    input  wire logic                done_i,        // Named test has finished
    output      logic [15:0]         pass_cnt_o,
    output      logic [15:0]         fail_cnt_o
);
    import ipic_pkg::*;

    csr_data_t   actual;
    int          test_errs = 0;    // Mismatches in running test
    logic [15:0] pass_cnt  = '0;
    logic [15:0] fail_cnt  = '0;

    assign actual = check_req_i ? {31'b0, irq_req_i} : rdata_i;

    // ----------------------------------------
    // Compare half a cycle after drive
    // ----------------------------------------
    always @(negedge clk) begin
        if (check_i && (actual !== exp_i)) begin
            $display("** Error %0s: expected %08h, actual %08h", name_i, exp_i, actual);
            test_errs = test_errs + 1;
        end
        if (done_i) begin
            if (test_errs == 0) begin
                $display("PASS  %0s", name_i);
                pass_cnt = pass_cnt + 1'b1;
            end else begin
                $display("FAIL  %0s with %0d mismatches", name_i, test_errs);
                fail_cnt = fail_cnt + 1'b1;
            end
            test_errs = 0;          // Next test starts clean
        end
    end

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

endmodule : ipic_checker

`default_nettype wire

/* bench/ipic_tb.sv */
// Testbench top: loads the command list from the tests file and runs it against the IPIC
`timescale 1ns/1ps
`default_nettype none

module ipic_tb;
    import ipic_pkg::*;

    localparam int DRV_DLY   = 2;   // Drive after rising edge
    localparam int CMD_LINES = 0;
    localparam int CMD_WR    = 1;
    localparam int CMD_RD    = 2;
    localparam int CMD_WAIT  = 3;
    localparam int CMD_REQ   = 4;

    logic      clk;
    logic      rst_n;
    irq_vec_t  irq_lines;
    logic      csr_r_req;
    logic      csr_w_req;
    csr_addr_t csr_addr;
    csr_data_t csr_wdata;
    csr_data_t csr_rdata;
    logic      irq_m_req;

    // Checker control
    logic         check;
    logic         check_req;
    csr_data_t    check_exp;
    logic [127:0] cur_name;
    logic         done;
    logic [15:0]  pass_cnt;
    logic [15:0]  fail_cnt;

    // Command list from file
    logic [127:0] name_q[$];
    int           cmd_q[$];
    logic [31:0]  arg0_q[$];
    logic [31:0]  arg1_q[$];
    logic         load_err;
    int           cycle_cnt = 0;
    int           cycle_limit;  // Zero until list is loaded

    ipic_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ipic_top u_ipic_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_lines_i (irq_lines),
        .csr_r_req_i (csr_r_req),
        .csr_w_req_i (csr_w_req),
        .csr_addr_i  (csr_addr),
        .csr_wdata_i (csr_wdata),
        .csr_rdata_o (csr_rdata),
        .irq_m_req_o (irq_m_req)
    );

    ipic_checker u_checker (
        .clk         (clk),
        .rdata_i     (csr_rdata),
        .irq_req_i   (irq_m_req),
        .check_i     (check),
        .check_req_i (check_req),
        .exp_i       (check_exp),
        .name_i      (cur_name),
        .done_i      (done),
        .pass_cnt_o  (pass_cnt),
        .fail_cnt_o  (fail_cnt)
    );

    // ----------------------------------------
    // Command file loading
    // ----------------------------------------
    function automatic int decode_cmd(input logic [63:0] c);
        if (c == 64'("lines")) return CMD_LINES;
        if (c == 64'("wr"))    return CMD_WR;
        if (c == 64'("rd"))    return CMD_RD;
        if (c == 64'("wait"))  return CMD_WAIT;
        if (c == 64'("req"))   return CMD_REQ;
        return -1;
    endfunction

    task automatic load_tests();
        int           fd;
        int           n;
        int           code;
        string        line_s;
        logic [127:0] name_v;
        logic [63:0]  cmd_v;
        logic [31:0]  a0;
        logic [31:0]  a1;
        fd = $fopen("bench/ipic_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the tests file bench/ipic_tests.txt");
            load_err = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            line_s = "";
            n = $fgets(line_s, fd);
            if (n <= 1 || line_s.getc(0) == "#") continue;     // Blank or comment
            n = $sscanf(line_s, "%s %s %h %h", name_v, cmd_v, a0, a1);
            code = decode_cmd(cmd_v);
            if (n != 4 || code < 0) begin
                $display("Malformed line in the tests file: %s", line_s);
                load_err = 1'b1;
                continue;
            end
            name_q.push_back(name_v);
            cmd_q.push_back(code);
            arg0_q.push_back(a0);
            arg1_q.push_back(a1);
        end
        $fclose(fd);
    endtask

    // ----------------------------------------
    // Drive tasks
    // ----------------------------------------
    task automatic drive_idle();
        csr_r_req = 1'b0;
        csr_w_req = 1'b0;
        check     = 1'b0;
        done      = 1'b0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRV_DLY;
        drive_idle();
    endtask

    // Tell the checker a test is over
    task automatic end_test(input logic [127:0] name);
        next_cycle();
        cur_name = name;
        done     = 1'b1;
    endtask

    task automatic run_cmd(input int i);
        next_cycle();
        cur_name = name_q[i];
        case (cmd_q[i])
            CMD_LINES: irq_lines = arg0_q[i][IRQ_VECT_NUM-1:0];
            CMD_WR: begin
                csr_w_req = 1'b1;
                csr_addr  = arg0_q[i][2:0];
                csr_wdata = arg1_q[i];
            end
            CMD_RD: begin
                csr_r_req = 1'b1;
                csr_addr  = arg0_q[i][2:0];
                check     = 1'b1;
                check_req = 1'b0;
                check_exp = arg1_q[i];
            end
            CMD_REQ: begin
                check     = 1'b1;
                check_req = 1'b1;
                check_exp = arg0_q[i];
            end
            CMD_WAIT: repeat (int'(arg0_q[i]) - 1) next_cycle();   // Own cycle counts
            default: ;
        endcase
    endtask

    // Run limit from the loaded list
    always @(posedge clk) begin
        if (rst_n && cycle_limit > 0) begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt >= cycle_limit) begin
                $display("Timeout: command list still running after %0d cycles", cycle_cnt);
                $display("Test FAILED");
                $finish;
            end
        end
    end

    initial begin
        irq_lines   = '0;
        csr_addr    = '0;
        csr_wdata   = '0;
        check_req   = 1'b0;
        check_exp   = '0;
        cur_name    = '0;
        load_err    = 1'b0;
        cycle_limit = 0;
        drive_idle();
        load_tests();
        for (int i = 0; i < cmd_q.size(); i++) begin
            cycle_limit += (cmd_q[i] == CMD_WAIT) ? int'(arg0_q[i]) + 1 : 1;
        end
        cycle_limit = 2 * cycle_limit;
        @(posedge rst_n);
        for (int i = 0; i < cmd_q.size(); i++) begin
            if (i > 0 && name_q[i] != name_q[i-1]) end_test(name_q[i-1]);
            run_cmd(i);
        end
        if (name_q.size() > 0) end_test(name_q[name_q.size()-1]);
        next_cycle();       // Last result printed at the negedge before
        $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0 && !load_err) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : ipic_tb

`default_nettype wire

/* bench/ipic_tests.txt */
# Columns: test name, command (lines, wr, rd, wait, req), arg0, arg1, all args hex
# lines: pin value | wr/rd: address, data or expected | wait: cycles | req: expected level
reset     rd    0 00000010
reset     rd    2 00000000
reset     rd    3 00000000
reset     rd    7 00000300
reset     req   0 0
level     wr    6 00000003
level     wr    7 00000002
level     lines 0008 0
level     wait  3 0
level     rd    2 00000008
level     req   1 0
level     lines 0000 0
level     wait  3 0
level     rd    2 00000000
level     req   0 0
start_end lines 0008 0
start_end wait  3 0
start_end wr    5 00000000
start_end rd    0 00000003
start_end rd    3 00000008
start_end lines 0000 0
start_end wait  3 0
start_end rd    1 00000002
start_end wr    4 00000000
start_end rd    0 00000010
start_end rd    3 00000000
priority  wr    6 00000005
priority  wr    7 00000002
priority  wr    6 00000002
priority  wr    7 00000002
priority  wr    6 00000001
priority  wr    7 00000002
priority  lines 0024 0
priority  wait  3 0
priority  wr    5 00000000
priority  rd    0 00000002
priority  lines 0020 0
priority  wait  3 0
priority  wr    4 00000000
priority  wr    5 00000000
priority  rd    0 00000005
priority  lines 0022 0
priority  wait  3 0
priority  req   1 0
priority  wr    5 00000000
priority  rd    3 00000022
priority  wr    4 00000000
priority  rd    0 00000005
priority  lines 0000 0
priority  wait  3 0
priority  wr    4 00000000
edge_inv  wr    6 00000007
edge_inv  wr    7 00000006
edge_inv  lines 0080 0
edge_inv  lines 0000 0
edge_inv  wait  3 0
edge_inv  rd    2 00000080
edge_inv  wr    2 00000080
edge_inv  rd    2 00000000
edge_inv  wr    7 00000000
edge_inv  wr    6 00000009
edge_inv  wr    7 00000008
edge_inv  wait  2 0
edge_inv  rd    2 00000200
icsr      wr    6 00000004
icsr      wr    7 00000006
icsr      lines 0010 0
icsr      lines 0000 0
icsr      wait  3 0
icsr      wr    5 00000000
icsr      lines 0010 0
icsr      lines 0000 0
icsr      wait  3 0
icsr      wr    7 0000000e
icsr      rd    7 0000431f
icsr      rd    1 00000003

/* all.f */
common/ipic_pkg.sv
common/ipic_reg_if.sv
source/ipic_line_frontend.sv
source/ipic_priority_search.sv
ipic_core/ipic_csr_ctrl.sv
ipic_core/ipic_line_regs.sv
ipic_core/ipic_service.sv
source/ipic_top.sv
bench/ipic_clkgen.sv
bench/ipic_checker.sv
bench/ipic_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the IPIC testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --top-module ipic_tb -f all.f --Mdir obj_dir -o ipic_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/ipic_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi

exit 0
